// File: hdl/dma_pkg.sv
/* widths, APB register offsets, word typedefs and engine state enums
   shared by the DMA copy blocks */

`default_nettype none

package dma_pkg;

    // memory side widths, addresses count 64-bit words and not bytes
    localparam int addr_w = 32;
    localparam int data_w = 64;
    localparam int len_w = 16;

    // FIFO depth doubles as the read credit limit, keep it a power of two
    localparam int fifo_depth = 8;
    localparam int ptr_w = $clog2(fifo_depth);
    localparam int cnt_w = $clog2(fifo_depth + 1);

    typedef logic [addr_w-1:0] mem_addr_t;
    typedef logic [data_w-1:0] mem_data_t;
    typedef logic [len_w-1:0] xfer_len_t;
    typedef logic [31:0] apb_data_t;
    typedef logic [cnt_w-1:0] fifo_cnt_t;

    // register map, byte offsets on the APB port
    localparam apb_data_t reg_ctrl = 32'h00;
    localparam apb_data_t reg_status = 32'h04;
    localparam apb_data_t reg_src = 32'h08;
    localparam apb_data_t reg_dst = 32'h0C;
    localparam apb_data_t reg_len = 32'h10;
    localparam apb_data_t reg_count = 32'h14;

    typedef enum logic [0:0] {rd_idle, rd_run} rd_state_t;
    typedef enum logic [1:0] {wr_idle, wr_run, wr_done} wr_state_t;

endpackage

`default_nettype wire

// File: hdl/dma_csr.sv
/* APB register block: source, destination and length registers, start
   control, busy and sticky done status, progress count and error flag */

`timescale 1ns/1ps
`default_nettype none

module dma_csr (
    input  logic               clk,
    input  logic               reset,
    input  dma_pkg::apb_data_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  dma_pkg::apb_data_t pwdata,
    input  logic               done_pulse,
    input  dma_pkg::xfer_len_t words_written,
    output dma_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               start,
    output dma_pkg::mem_addr_t src_addr,
    output dma_pkg::mem_addr_t dst_addr,
    output dma_pkg::xfer_len_t xfer_len,
    output logic               irq
);

    logic access;
    logic wr_en;
    logic addr_ok;
    logic ro_hit;
    logic start_req;
    logic start_err;
    logic busy;
    logic done;

    // =========================================================================
    // APB decode
    // =========================================================================

    // no wait states, so every access finishes in its access phase
    assign pready = 1'b1;
    assign access = psel & penable;

    // read mux, an offset that misses every case is reported as unmapped
    always_comb begin
        prdata = '0;
        addr_ok = 1'b1;
        case (paddr)
            dma_pkg::reg_ctrl:   prdata = '0;
            dma_pkg::reg_status: prdata = dma_pkg::apb_data_t'({done, busy});
            dma_pkg::reg_src:    prdata = dma_pkg::apb_data_t'(src_addr);
            dma_pkg::reg_dst:    prdata = dma_pkg::apb_data_t'(dst_addr);
            dma_pkg::reg_len:    prdata = dma_pkg::apb_data_t'(xfer_len);
            dma_pkg::reg_count:  prdata = dma_pkg::apb_data_t'(words_written);
            default:             addr_ok = 1'b0;
        endcase
    end

    // status and count are read only
    assign ro_hit = pwrite &&
                    (paddr == dma_pkg::reg_status || paddr == dma_pkg::reg_count);

    // a start request while a copy runs is flagged and dropped
    assign start_req = pwrite && (paddr == dma_pkg::reg_ctrl) && pwdata[0];
    assign start_err = start_req && busy;

    assign pslverr = access && (!addr_ok || ro_hit || start_err);
    assign wr_en = access && pwrite && !pslverr;

    // =========================================================================
    // registers
    // =========================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            src_addr <= '0;
            dst_addr <= '0;
            xfer_len <= '0;
            start <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    dma_pkg::reg_src: src_addr <= dma_pkg::mem_addr_t'(pwdata);
                    dma_pkg::reg_dst: dst_addr <= dma_pkg::mem_addr_t'(pwdata);
                    dma_pkg::reg_len: xfer_len <= dma_pkg::xfer_len_t'(pwdata);
                    default: ;
                endcase
            end
            // start pulses in the cycle after the access phase, and busy
            // rises with it so a status read in that cycle already sees 1
            if (wr_en && start_req) begin
                start <= 1'b1;
                busy <= 1'b1;
                done <= 1'b0;
            end else if (done_pulse) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // interrupt is simply the level of the sticky done bit
    assign irq = done;

    // the engines latch their settings on start, a second one mid copy
    // would restart them with half the data still in flight
    a_start_idle: assert property (@(posedge clk) disable iff (reset)
        $rose(start) |-> !$past(busy))
        else $error("start raised while a copy was busy");

endmodule

`default_nettype wire

// File: hdl/dma_read_engine.sv
/* read engine: walks the source range, issues credit limited reads and
   pushes every read return into the data FIFO */

`timescale 1ns/1ps
`default_nettype none

module dma_read_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  dma_pkg::mem_addr_t src_addr,
    input  dma_pkg::xfer_len_t xfer_len,
    input  logic               gnt_ready,
    input  logic               mem_rvalid,
    input  dma_pkg::mem_data_t mem_rdata,
    input  dma_pkg::fifo_cnt_t fifo_count,
    output logic               rd_req,
    output dma_pkg::mem_addr_t rd_addr,
    output logic               push,
    output dma_pkg::mem_data_t push_data
);

    dma_pkg::rd_state_t state;
    dma_pkg::mem_addr_t addr_q;
    dma_pkg::xfer_len_t remain;
    dma_pkg::fifo_cnt_t outstanding;
    logic [dma_pkg::cnt_w:0] in_use;
    logic credit_ok;
    logic issue;

    // every read in flight owns a FIFO slot, so returns can always land
    // even while the write engine is stalled on the shared bus
    assign in_use = {1'b0, outstanding} + {1'b0, fifo_count};
    assign credit_ok = in_use < (dma_pkg::cnt_w + 1)'(dma_pkg::fifo_depth);

    // a pending request keeps its credit, since a return moves a slot
    // from outstanding to the FIFO and a pop only frees one
    assign rd_req = (state == dma_pkg::rd_run) && credit_ok;
    assign rd_addr = addr_q;
    assign issue = rd_req && gnt_ready;

    // returns carry no back-pressure and go straight into the FIFO
    assign push = mem_rvalid;
    assign push_data = mem_rdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dma_pkg::rd_idle;
            addr_q <= '0;
            remain <= '0;
        end else begin
            case (state)
                dma_pkg::rd_idle: begin
                    if (start) begin
                        addr_q <= src_addr;
                        remain <= xfer_len;
                        // a zero length copy reads nothing
                        if (xfer_len != '0) begin
                            state <= dma_pkg::rd_run;
                        end
                    end
                end
                dma_pkg::rd_run: begin
                    if (issue) begin
                        addr_q <= addr_q + 1'b1;
                        remain <= remain - 1'b1;
                        if (remain == dma_pkg::xfer_len_t'(1)) begin
                            state <= dma_pkg::rd_idle;
                        end
                    end
                end
                default: state <= dma_pkg::rd_idle;
            endcase
        end
    end

    // outstanding reads, up on acceptance and down on return
    always_ff @(posedge clk) begin
        if (reset) begin
            outstanding <= '0;
        end else begin
            case ({issue, mem_rvalid})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: ;
            endcase
        end
    end

    // the credit rule across engine, FIFO and memory
    a_credit: assert property (@(posedge clk) disable iff (reset)
        in_use <= (dma_pkg::cnt_w + 1)'(dma_pkg::fifo_depth))
        else $error("reads in flight plus FIFO words exceed the FIFO depth");

    // the memory must not return data that was never asked for
    a_return: assert property (@(posedge clk) disable iff (reset)
        mem_rvalid |-> outstanding != '0)
        else $error("read return with no read outstanding");

endmodule

`default_nettype wire

// File: hdl/dma_write_engine.sv
/* write engine: drains FIFO words into destination writes, counts the
   words written and signals the end of the copy */

`timescale 1ns/1ps
`default_nettype none

module dma_write_engine (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  dma_pkg::mem_addr_t dst_addr,
    input  dma_pkg::xfer_len_t xfer_len,
    input  logic               gnt_ready,
    input  logic               empty,
    input  dma_pkg::mem_data_t pop_data,
    output logic               wr_req,
    output dma_pkg::mem_addr_t wr_addr,
    output dma_pkg::mem_data_t wr_data,
    output logic               pop,
    output logic               done_pulse,
    output dma_pkg::xfer_len_t words_written
);

    dma_pkg::wr_state_t state;
    dma_pkg::mem_addr_t addr_q;
    dma_pkg::xfer_len_t len_q;
    logic accept;

    // the FIFO head is the write data, it stays put until the pop,
    // so a stalled request holds its data without a staging register
    assign wr_req = (state == dma_pkg::wr_run) && !empty;
    assign wr_addr = addr_q;
    assign wr_data = pop_data;
    assign accept = wr_req && gnt_ready;
    assign pop = accept;

    // done lasts the single cycle spent in wr_done
    assign done_pulse = (state == dma_pkg::wr_done);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dma_pkg::wr_idle;
            addr_q <= '0;
            len_q <= '0;
            words_written <= '0;
        end else begin
            case (state)
                dma_pkg::wr_idle: begin
                    if (start) begin
                        addr_q <= dst_addr;
                        len_q <= xfer_len;
                        words_written <= '0;
                        // length 0 goes straight to done, one cycle after start
                        state <= (xfer_len == '0) ? dma_pkg::wr_done : dma_pkg::wr_run;
                    end
                end
                dma_pkg::wr_run: begin
                    if (accept) begin
                        addr_q <= addr_q + 1'b1;
                        words_written <= words_written + 1'b1;
                        if (words_written + 1'b1 == len_q) begin
                            state <= dma_pkg::wr_done;
                        end
                    end
                end
                dma_pkg::wr_done: state <= dma_pkg::wr_idle;
                default: state <= dma_pkg::wr_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/dma_fifo.sv
/* synchronous data FIFO between the read and write engines */

`timescale 1ns/1ps
`default_nettype none

module dma_fifo (
    input  logic               clk,
    input  logic               reset,
    input  logic               push,
    input  dma_pkg::mem_data_t push_data,
    input  logic               pop,
    output dma_pkg::mem_data_t pop_data,
    output logic               empty,
    output dma_pkg::fifo_cnt_t count
);

    dma_pkg::mem_data_t mem [dma_pkg::fifo_depth];
    logic [dma_pkg::ptr_w-1:0] wr_ptr;
    logic [dma_pkg::ptr_w-1:0] rd_ptr;

    // storage, no reset since words are only read below count
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // pointers wrap on their own because the depth is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    // head word, valid whenever empty is low
    assign pop_data = mem[rd_ptr];
    assign empty = (count == '0);

    // overflow would mean the read credit rule broke upstream
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        push |-> count != (dma_pkg::cnt_w)'(dma_pkg::fifo_depth))
        else $error("push into a full FIFO");

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        pop |-> !empty)
        else $error("pop from an empty FIFO");

endmodule

`default_nettype wire

// File: hdl/mem_arbiter.sv
/* round-robin arbiter sharing the memory request bus between the read
   and write engines, with the grant locked through ready stalls */

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
    input  logic               clk,
    input  logic               reset,
    input  logic               rd_req,
    input  dma_pkg::mem_addr_t rd_addr,
    input  logic               wr_req,
    input  dma_pkg::mem_addr_t wr_addr,
    input  dma_pkg::mem_data_t wr_data,
    input  logic               mem_ready,
    output logic               rd_gnt_ready,
    output logic               wr_gnt_ready,
    output logic               mem_req,
    output logic               mem_we,
    output dma_pkg::mem_addr_t mem_addr,
    output dma_pkg::mem_data_t mem_wdata
);

    logic gnt_wr;
    logic prio_wr;
    logic locked;
    logic lock_wr;

    // a stalled request keeps its grant, otherwise the pointer breaks ties
    // and a lone requester wins outright
    always_comb begin
        if (locked) begin
            gnt_wr = lock_wr;
        end else if (rd_req && wr_req) begin
            gnt_wr = prio_wr;
        end else begin
            gnt_wr = wr_req;
        end
    end

    // shared bus, combinational from the engine requests
    assign mem_req = rd_req | wr_req;
    assign mem_we = gnt_wr;
    assign mem_addr = gnt_wr ? wr_addr : rd_addr;
    assign mem_wdata = gnt_wr ? wr_data : '0;

    // acceptance goes back only to the engine that holds the grant
    assign rd_gnt_ready = rd_req && !gnt_wr && mem_ready;
    assign wr_gnt_ready = wr_req && gnt_wr && mem_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_wr <= 1'b0;
            locked <= 1'b0;
            lock_wr <= 1'b0;
        end else if (mem_req && mem_ready) begin
            // after a transfer the other side gets the next tie
            locked <= 1'b0;
            prio_wr <= !gnt_wr;
        end else if (mem_req) begin
            locked <= 1'b1;
            lock_wr <= gnt_wr;
        end
    end

    // the memory may sample the request on any cycle of a stall
    a_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req && !mem_ready |=>
            mem_req && $stable(mem_addr) && $stable(mem_we) &&
            (!mem_we || $stable(mem_wdata)))
        else $error("memory request changed while stalled");

endmodule

`default_nettype wire

// File: hdl/dma_top.sv
/* DMA copy top level: register block, read and write engines, data FIFO
   and memory arbiter wired to the APB and memory ports */

`timescale 1ns/1ps
`default_nettype none

module dma_top (
    input  logic               clk,
    input  logic               reset,
    input  dma_pkg::apb_data_t paddr,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  dma_pkg::apb_data_t pwdata,
    output dma_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               mem_req,
    output logic               mem_we,
    output dma_pkg::mem_addr_t mem_addr,
    output dma_pkg::mem_data_t mem_wdata,
    input  logic               mem_ready,
    input  logic               mem_rvalid,
    input  dma_pkg::mem_data_t mem_rdata,
    output logic               irq
);

    // control between the register block and the engines
    logic               start;
    dma_pkg::mem_addr_t src_addr;
    dma_pkg::mem_addr_t dst_addr;
    dma_pkg::xfer_len_t xfer_len;
    logic               done_pulse;
    dma_pkg::xfer_len_t words_written;

    // engine requests into the arbiter
    logic               rd_req;
    dma_pkg::mem_addr_t rd_addr;
    logic               rd_gnt_ready;
    logic               wr_req;
    dma_pkg::mem_addr_t wr_addr;
    dma_pkg::mem_data_t wr_data;
    logic               wr_gnt_ready;

    // data path through the FIFO
    logic               push;
    dma_pkg::mem_data_t push_data;
    logic               pop;
    dma_pkg::mem_data_t pop_data;
    logic               empty;
    dma_pkg::fifo_cnt_t fifo_count;

    dma_csr u_csr (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .done_pulse(done_pulse), .words_written(words_written),
        .prdata(prdata), .pready(pready), .pslverr(pslverr), .start(start),
        .src_addr(src_addr), .dst_addr(dst_addr), .xfer_len(xfer_len), .irq(irq)
    );

    dma_read_engine u_read (
        .clk(clk), .reset(reset),
        .start(start), .src_addr(src_addr), .xfer_len(xfer_len),
        .gnt_ready(rd_gnt_ready), .mem_rvalid(mem_rvalid), .mem_rdata(mem_rdata),
        .fifo_count(fifo_count), .rd_req(rd_req), .rd_addr(rd_addr),
        .push(push), .push_data(push_data)
    );

    dma_fifo u_fifo (
        .clk(clk), .reset(reset),
        .push(push), .push_data(push_data), .pop(pop),
        .pop_data(pop_data), .empty(empty), .count(fifo_count)
    );

    dma_write_engine u_write (
        .clk(clk), .reset(reset),
        .start(start), .dst_addr(dst_addr), .xfer_len(xfer_len),
        .gnt_ready(wr_gnt_ready), .empty(empty), .pop_data(pop_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .pop(pop),
        .done_pulse(done_pulse), .words_written(words_written)
    );

    mem_arbiter u_arb (
        .clk(clk), .reset(reset),
        .rd_req(rd_req), .rd_addr(rd_addr),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data),
        .mem_ready(mem_ready), .rd_gnt_ready(rd_gnt_ready),
        .wr_gnt_ready(wr_gnt_ready), .mem_req(mem_req), .mem_we(mem_we),
        .mem_addr(mem_addr), .mem_wdata(mem_wdata)
    );

endmodule

`default_nettype wire

// File: tb/mem_model.sv
/* behavioral word memory for the DMA testbench: random ready stalls,
   in-order read returns after 1 to 4 cycles, and a backdoor write port */

`timescale 1ns/1ps
`default_nettype none

module mem_model (
    input  logic               clk,
    input  logic               reset,
    input  logic               mem_req,
    input  logic               mem_we,
    input  dma_pkg::mem_addr_t mem_addr,
    input  dma_pkg::mem_data_t mem_wdata,
    output logic               mem_ready,
    output logic               mem_rvalid,
    output dma_pkg::mem_data_t mem_rdata,
    input  logic [6:0]         stall_pct,
    input  logic               bd_we,
    input  logic [11:0]        bd_addr,
    input  dma_pkg::mem_data_t bd_wdata
);

    // 4096 words, only the low 12 address bits select a word
    dma_pkg::mem_data_t words [4096];

    // reads accepted but not yet returned, with the cycle each falls due
    dma_pkg::mem_data_t rd_data_q [$];
    int rd_due_q [$];
    int cyc;

    always @(posedge clk) begin
        if (reset) begin
            // background pattern built from the whole word address
            for (int i = 0; i < 4096; i++) begin
                words[i] <= {32'hdead_0000 ^ 32'(i), 32'(i) * 32'h9e37_79b1};
            end
            rd_data_q.delete();
            rd_due_q.delete();
            cyc = 0;
            mem_ready <= 1'b0;
            mem_rvalid <= 1'b0;
            mem_rdata <= '0;
        end else begin
            cyc = cyc + 1;
            mem_ready <= ($urandom % 100) >= 32'(stall_pct);
            // returns leave strictly in request order, one per cycle at most
            mem_rvalid <= 1'b0;
            if (rd_due_q.size() > 0 && rd_due_q[0] <= cyc) begin
                mem_rvalid <= 1'b1;
                mem_rdata <= rd_data_q.pop_front();
                void'(rd_due_q.pop_front());
            end
            if (mem_req && mem_ready) begin
                if (mem_we) begin
                    words[mem_addr[11:0]] <= mem_wdata;
                end else begin
                    rd_data_q.push_back(words[mem_addr[11:0]]);
                    rd_due_q.push_back(cyc + 1 + int'($urandom % 4));
                end
            end
            // backdoor preload, used only while the DMA is idle
            if (bd_we) begin
                words[bd_addr] <= bd_wdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/tb_dma_top.sv
/* DMA copy testbench: clock and reset, APB access tasks, memory model
   and directed tests for registers, copies, stalls, errors and restart */

`timescale 1ns/1ps
`default_nettype none

module tb_dma_top;

    localparam int timeout_cycles = 20000;

    logic               clk;
    logic               reset;
    dma_pkg::apb_data_t paddr;
    dma_pkg::apb_data_t pwdata;
    dma_pkg::apb_data_t prdata;
    logic               psel;
    logic               penable;
    logic               pwrite;
    logic               pready;
    logic               pslverr;
    logic               mem_req;
    logic               mem_we;
    logic               mem_ready;
    logic               mem_rvalid;
    logic               irq;
    dma_pkg::mem_addr_t mem_addr;
    dma_pkg::mem_data_t mem_wdata;
    dma_pkg::mem_data_t mem_rdata;
    logic [6:0]         stall_pct;
    logic               bd_we;
    logic [11:0]        bd_addr;
    dma_pkg::mem_data_t bd_wdata;

    // expected memory contents, kept by the testbench alongside the model
    dma_pkg::mem_data_t ref_mem [4096];
    int checks;
    int errors;
    logic timed_out;

    dma_top uut (
        .clk(clk), .reset(reset),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata), .irq(irq)
    );

    mem_model u_mem (
        .clk(clk), .reset(reset),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr),
        .mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rvalid(mem_rvalid),
        .mem_rdata(mem_rdata), .stall_pct(stall_pct),
        .bd_we(bd_we), .bd_addr(bd_addr), .bd_wdata(bd_wdata)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ========================================================================
    // checking and APB access
    // ========================================================================

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0d ns: %s, got %0h, expected %0h", $time, msg, got, exp);
        end
    endtask

    // setup phase, access phase, then sample in the middle of the access phase
    task automatic apb_access(input logic wr, input dma_pkg::apb_data_t addr,
                              input dma_pkg::apb_data_t wdata,
                              output dma_pkg::apb_data_t rdata, output logic err);
        @(posedge clk);
        psel <= 1'b1;
        penable <= 1'b0;
        pwrite <= wr;
        paddr <= addr;
        pwdata <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        psel <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input dma_pkg::apb_data_t addr, input dma_pkg::apb_data_t data,
                             input logic exp_err, input string msg);
        dma_pkg::apb_data_t unused;
        logic err;
        apb_access(1'b1, addr, data, unused, err);
        check(64'(err), 64'(exp_err), {msg, " error flag"});
    endtask

    task automatic read_reg(input dma_pkg::apb_data_t addr, input dma_pkg::apb_data_t exp,
                            input logic exp_err, input string msg);
        dma_pkg::apb_data_t data;
        logic err;
        apb_access(1'b0, addr, 32'h0, data, err);
        check(64'(data), 64'(exp), msg);
        check(64'(err), 64'(exp_err), {msg, " error flag"});
    endtask

    task automatic check_irq(input logic exp, input string msg);
        @(negedge clk);
        check(64'(irq), 64'(exp), msg);
    endtask

    // ========================================================================
    // memory and transfer helpers
    // ========================================================================

    task automatic set_stall(input int pct);
        @(posedge clk);
        stall_pct <= 7'(pct);
    endtask

    // random words loaded through the model's backdoor port
    task automatic fill_random(input int base, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            bd_we <= 1'b1;
            bd_addr <= 12'(base + i);
            bd_wdata <= {$urandom, $urandom};
        end
        @(posedge clk);
        bd_we <= 1'b0;
        @(negedge clk);
    endtask

    task automatic snapshot_memory();
        for (int i = 0; i < 4096; i++) begin
            ref_mem[i] = u_mem.words[i];
        end
    endtask

    task automatic compare_memory(input string msg);
        for (int i = 0; i < 4096; i++) begin
            check(u_mem.words[i], ref_mem[i], $sformatf("%s word 0x%03h", msg, i));
        end
    endtask

    // programs the registers and starts; the expected image gets the copy
    task automatic start_copy(input int src, input int dst, input int len);
        write_reg(dma_pkg::reg_src, 32'(src), 1'b0, "write src");
        write_reg(dma_pkg::reg_dst, 32'(dst), 1'b0, "write dst");
        write_reg(dma_pkg::reg_len, 32'(len), 1'b0, "write len");
        write_reg(dma_pkg::reg_ctrl, 32'h1, 1'b0, "start");
        for (int i = 0; i < len; i++) begin
            ref_mem[dst + i] = ref_mem[src + i];
        end
    endtask

    // the start edge clears done, so irq is first looked at half a cycle later
    task automatic wait_irq(input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!irq && n < timeout_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!irq) begin
            errors++;
            timed_out = 1'b1;
            $display("ERROR at %0d ns: %s transfer did not finish within %0d cycles",
                     $time, name, timeout_cycles);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("test %-18s %s", name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================

    task automatic test_registers();
        int e;
        e = errors;
        for (int a = 0; a < 24; a += 4) begin
            read_reg(32'(a), 32'h0, 1'b0, $sformatf("register 0x%02h after reset", a));
        end
        check_irq(1'b0, "irq after reset");
        check(64'(pready), 64'h1, "pready");
        write_reg(dma_pkg::reg_src, 32'h0000_0123, 1'b0, "write src");
        write_reg(dma_pkg::reg_dst, 32'h0000_0456, 1'b0, "write dst");
        write_reg(dma_pkg::reg_len, 32'h0000_0789, 1'b0, "write len");
        read_reg(dma_pkg::reg_src, 32'h0000_0123, 1'b0, "src readback");
        read_reg(dma_pkg::reg_dst, 32'h0000_0456, 1'b0, "dst readback");
        read_reg(dma_pkg::reg_len, 32'h0000_0789, 1'b0, "len readback");
        report_test("registers", e);
    endtask

    task automatic test_basic_copy();
        int e;
        e = errors;
        fill_random(32'h100, 20);
        snapshot_memory();
        start_copy(32'h100, 32'h300, 20);
        wait_irq("basic");
        compare_memory("basic copy");
        read_reg(dma_pkg::reg_count, 32'd20, 1'b0, "count after basic copy");
        // status is {done, busy}
        read_reg(dma_pkg::reg_status, 32'h2, 1'b0, "status after basic copy");
        check_irq(1'b1, "irq after basic copy");
        report_test("basic_copy", e);
    endtask

    task automatic test_backpressure();
        int e;
        e = errors;
        set_stall(70);
        fill_random(32'h400, 100);
        snapshot_memory();
        start_copy(32'h400, 32'h800, 100);
        wait_irq("back-pressure");
        compare_memory("stalled copy");
        read_reg(dma_pkg::reg_count, 32'd100, 1'b0, "count after stalled copy");
        read_reg(dma_pkg::reg_status, 32'h2, 1'b0, "status after stalled copy");
        set_stall(25);
        report_test("backpressure", e);
    endtask

    task automatic test_errors();
        int e;
        e = errors;
        read_reg(32'h18, 32'h0, 1'b1, "read of unmapped offset");
        write_reg(32'h40, 32'h5, 1'b1, "write of unmapped offset");
        write_reg(dma_pkg::reg_count, 32'h5, 1'b1, "write to count");
        write_reg(dma_pkg::reg_status, 32'h3, 1'b1, "write to status");
        // a long copy keeps busy up while the second start arrives
        set_stall(60);
        snapshot_memory();
        start_copy(32'h400, 32'ha00, 300);
        write_reg(dma_pkg::reg_ctrl, 32'h1, 1'b1, "start while busy");
        read_reg(dma_pkg::reg_status, 32'h1, 1'b0, "status during long copy");
        wait_irq("long");
        compare_memory("long copy");
        read_reg(dma_pkg::reg_count, 32'd300, 1'b0, "count after long copy");
        read_reg(dma_pkg::reg_status, 32'h2, 1'b0, "status after long copy");
        set_stall(25);
        report_test("errors", e);
    endtask

    task automatic test_zero_restart();
        int e;
        e = errors;
        snapshot_memory();
        start_copy(32'h100, 32'hc00, 0);
        wait_irq("zero length");
        read_reg(dma_pkg::reg_status, 32'h2, 1'b0, "status after zero length");
        read_reg(dma_pkg::reg_count, 32'h0, 1'b0, "count after zero length");
        compare_memory("zero length");
        // the next start drops done before the copy ends
        start_copy(32'h100, 32'hd00, 20);
        read_reg(dma_pkg::reg_status, 32'h1, 1'b0, "status after restart");
        check_irq(1'b0, "irq after restart");
        wait_irq("restart");
        compare_memory("restart copy");
        read_reg(dma_pkg::reg_count, 32'd20, 1'b0, "count after restart copy");
        read_reg(dma_pkg::reg_status, 32'h2, 1'b0, "status after restart copy");
        report_test("zero_restart", e);
    endtask

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        stall_pct = 7'd25;
        bd_we = 1'b0;
        bd_addr = '0;
        bd_wdata = '0;
        checks = 0;
        errors = 0;
        timed_out = 1'b0;
        void'($urandom(84916));
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        test_registers();
        // a hung DMA would only make every later test wait out its timeout
        if (!timed_out) test_basic_copy();
        if (!timed_out) test_backpressure();
        if (!timed_out) test_errors();
        if (!timed_out) test_zero_restart();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
hdl/dma_pkg.sv
hdl/dma_csr.sv
hdl/dma_read_engine.sv
hdl/dma_write_engine.sv
hdl/dma_fifo.sv
hdl/mem_arbiter.sv
hdl/dma_top.sv
tb/mem_model.sv
tb/tb_dma_top.sv

// File: Makefile
# Verilator build and run of the DMA copy testbench

VERILATOR ?= verilator
TOP       ?= tb_dma_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "All checks passed" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
